/* core_checker.sv */
`default_nettype none

module core_checker import rv_pkg::*; (
  input logic clk,
  input logic reset,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_we,
  input logic wb_ack,
  input logic [xlen-1:0] wb_adr,
  input logic [xlen-1:0] wb_dat_w,
  input logic [mask_width-1:0] wb_sel,
  input logic halted,
  input core_state_e state,
  input imm_kind_e imm_kind
);

  // assertion failures so far
  int fail_count = 0;

  // strobe only inside a cycle
  stb_in_cyc: assert property (@(posedge clk) disable iff (reset)
    wb_stb |-> wb_cyc)
    else begin
      fail_count++;
      $error("wishbone stb high without cyc");
    end

  // payload frozen until ack
  payload_held: assert property (@(posedge clk) disable iff (reset)
    (wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_dat_w) &&
                             $stable(wb_we) && $stable(wb_sel)))
    else begin
      fail_count++;
      $error("wishbone payload changed while waiting for ack");
    end

  // bus quiet once parked
  quiet_halt: assert property (@(posedge clk) disable iff (reset)
    (halted || state == st_halted) |-> !wb_cyc)
    else begin
      fail_count++;
      $error("bus cycle while halted");
    end

  // sticky until reset
  halt_sticky: assert property (@(posedge clk) disable iff (reset)
    halted |=> halted)
    else begin
      fail_count++;
      $error("halted dropped without reset");
    end

  // a store cycle only ever follows an s-type instruction
  store_from_sd: assert property (@(posedge clk) disable iff (reset)
    (state == st_store) |-> (imm_kind == imm_s && wb_we))
    else begin
      fail_count++;
      $error("store cycle without an s-type instruction");
    end

endmodule

bind rv_core core_checker u_checker (
  .clk      (clk),
  .reset    (reset),
  .wb_cyc   (wb_cyc),
  .wb_stb   (wb_stb),
  .wb_we    (wb_we),
  .wb_ack   (wb_ack),
  .wb_adr   (wb_adr),
  .wb_dat_w (wb_dat_w),
  .wb_sel   (wb_sel),
  .halted   (halted),
  .state    (u_core_ctrl.state),
  .imm_kind (u_dec_if.imm_kind)
);

`default_nettype wire

/* core_ctrl.sv */
`default_nettype none

module core_ctrl import rv_pkg::*; (
  input logic clk,
  input logic reset,
  dec_if.consumer dec,
  input logic [xlen-1:0] next_pc,
  input logic [xlen-1:0] mem_addr,
  input logic [xlen-1:0] mem_data,
  output logic [inst_width-1:0] inst,
  output logic [xlen-1:0] pc,
  output logic reg_we,
  output logic [xlen-1:0] wb_adr,
  output logic [xlen-1:0] wb_dat_w,
  input logic [xlen-1:0] wb_dat_r,
  output logic [mask_width-1:0] wb_sel,
  output logic wb_we,
  output logic wb_cyc,
  output logic wb_stb,
  input logic wb_ack,
  output logic halted,
  output logic illegal
);

  core_state_e state;
  // instruction register
  logic [inst_width-1:0] ir;
  // doubleword holding the current instruction
  logic [xlen-1:0] fetch_adr;

  logic fetch_start;
  logic fetch_done;
  logic store_start;
  logic store_done;

  // bit 2 cleared, upper half picked on return
  assign fetch_adr = {pc[xlen-1:3], 1'b0, pc[1:0]};

  // bus events
  // fetch opens one cycle after entering fetch
  assign fetch_start = (state == st_fetch) && !wb_cyc;
  assign fetch_done = (state == st_fetch) && wb_cyc && wb_ack;
  // sd leaves execute for a bus write
  assign store_start = (state == st_execute) && dec.mem_wen && !dec.not_impl;
  assign store_done = (state == st_store) && wb_ack;

  // control state
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_fetch;
      pc <= reset_pc;
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we <= 1'b0;
      halted <= 1'b0;
      illegal <= 1'b0;
    end else begin
      unique case (state)
        st_fetch: begin
          if (fetch_start) begin
            wb_cyc <= 1'b1;
            wb_stb <= 1'b1;
            wb_we <= 1'b0;
          end else if (fetch_done) begin
            // cycle ends on the edge after ack
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            state <= st_execute;
          end
        end
        st_execute: begin
          // pc left on the faulting instruction
          if (dec.not_impl) begin
            state <= st_halted;
            halted <= 1'b1;
            illegal <= 1'b1;
          end else if (dec.is_ebreak) begin
            state <= st_halted;
            halted <= 1'b1;
          end else begin
            pc <= next_pc;
            if (store_start) begin
              wb_cyc <= 1'b1;
              wb_stb <= 1'b1;
              wb_we <= 1'b1;
              state <= st_store;
            end else begin
              state <= st_fetch;
            end
          end
        end
        st_store: begin
          if (store_done) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we <= 1'b0;
            state <= st_fetch;
          end
        end
        st_halted: begin
          // parked until reset
          state <= st_halted;
        end
      endcase
    end
  end

  // bus payload and instruction register
  // held while waiting for ack
  always_ff @(posedge clk) begin
    if (fetch_start) begin
      wb_adr <= fetch_adr;
      wb_sel <= '1;
    end
    if (fetch_done) begin
      ir <= pc[2] ? wb_dat_r[xlen-1:inst_width] : wb_dat_r[inst_width-1:0];
    end
    if (store_start) begin
      wb_adr <= mem_addr;
      wb_dat_w <= mem_data;
      wb_sel <= dec.wmask;
    end
  end

  assign inst = ir;

  // write-back only in the execute cycle
  assign reg_we = (state == st_execute) && dec.reg_wen;

endmodule

`default_nettype wire

/* dec_if.sv */
`default_nettype none

interface dec_if import rv_pkg::*; ();

  // register indices straight from the instruction
  logic [reg_id_width-1:0] rd;
  logic [reg_id_width-1:0] rs1;
  logic [reg_id_width-1:0] rs2;
  // sign-extended immediate and its format
  logic [xlen-1:0] imm;
  imm_kind_e imm_kind;
  // execution controls
  logic need_imm;
  logic alu_add;
  logic is_auipc;
  logic is_jal;
  logic is_ebreak;
  // write enables and store byte mask
  logic reg_wen;
  logic mem_wen;
  logic [mask_width-1:0] wmask;
  // none of the known forms
  logic not_impl;

  modport decoder (
    output rd, rs1, rs2, imm, imm_kind, need_imm, alu_add, is_auipc,
    output is_jal, is_ebreak, reg_wen, mem_wen, wmask, not_impl
  );

  modport consumer (
    input rd, rs1, rs2, imm, imm_kind, need_imm, alu_add, is_auipc,
    input is_jal, is_ebreak, reg_wen, mem_wen, wmask, not_impl
  );

endinterface

`default_nettype wire

/* decoder.sv */
`default_nettype none

module decoder import rv_pkg::*; (
  input logic [inst_width-1:0] inst,
  dec_if.decoder dec
);

  opcode_e opcode;
  logic [2:0] funct3;
  logic [11:0] funct12;

  logic is_nop;
  logic is_addi;
  logic is_auipc;
  logic is_jal;
  logic is_sd;
  logic is_ebreak;

  imm_kind_e kind;
  // one candidate per immediate format
  logic [xlen-1:0] imm_i_val;
  logic [xlen-1:0] imm_u_val;
  logic [xlen-1:0] imm_j_val;
  logic [xlen-1:0] imm_s_val;

  // field extraction
  assign opcode = opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign funct12 = inst[31:20];

  // all-zero word runs as a no-op
  assign is_nop = (inst == '0);
  assign is_addi = (opcode == opc_op_imm) && (funct3 == f3_addi);
  assign is_auipc = (opcode == opc_auipc);
  assign is_jal = (opcode == opc_jal);
  // only the doubleword store
  assign is_sd = (opcode == opc_store) && (funct3 == f3_sd);
  assign is_ebreak = (opcode == opc_system) && (funct3 == f3_priv) &&
                     (funct12 == f12_ebreak);

  // format chosen by opcode alone
  always_comb begin
    unique case (opcode)
      opc_op_imm: kind = imm_i;
      opc_auipc:  kind = imm_u;
      opc_jal:    kind = imm_j;
      opc_store:  kind = imm_s;
      default:    kind = imm_none;
    endcase
  end

  // sign bit is always inst[31]
  assign imm_i_val = {{(xlen-12){inst[31]}}, inst[31:20]};
  assign imm_u_val = {{(xlen-32){inst[31]}}, inst[31:12], 12'b0};
  // j-type scrambled offset, bit 0 implied zero
  assign imm_j_val = {{(xlen-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  assign imm_s_val = {{(xlen-12){inst[31]}}, inst[31:25], inst[11:7]};

  always_comb begin
    unique case (kind)
      imm_i:   dec.imm = imm_i_val;
      imm_u:   dec.imm = imm_u_val;
      imm_j:   dec.imm = imm_j_val;
      imm_s:   dec.imm = imm_s_val;
      default: dec.imm = '0;
    endcase
  end

  assign dec.imm_kind = kind;

  // register indices, valid or not
  assign dec.rd = inst[11:7];
  assign dec.rs1 = inst[19:15];
  assign dec.rs2 = inst[24:20];

  // adder used by addi, auipc and the sd address
  assign dec.alu_add = is_addi | is_auipc | is_sd;
  // second operand from imm rather than rs2
  assign dec.need_imm = (opcode == opc_op_imm) | is_auipc | is_sd;

  assign dec.is_auipc = is_auipc;
  assign dec.is_jal = is_jal;
  assign dec.is_ebreak = is_ebreak;

  // addi writes back too, jal writes the link
  assign dec.reg_wen = is_addi | is_auipc | is_jal;
  assign dec.mem_wen = is_sd;
  // full doubleword for sd
  assign dec.wmask = is_sd ? '1 : '0;

  assign dec.not_impl = ~(is_addi | is_auipc | is_jal | is_sd | is_ebreak | is_nop);

endmodule

`default_nettype wire

/* exec_unit.sv */
`default_nettype none

module exec_unit import rv_pkg::*; (
  input logic [xlen-1:0] pc,
  input logic [xlen-1:0] rs1_val,
  input logic [xlen-1:0] rs2_val,
  dec_if.consumer dec,
  output logic [xlen-1:0] next_pc,
  output logic [xlen-1:0] wb_data,
  output logic [xlen-1:0] mem_addr,
  output logic [xlen-1:0] mem_data
);

  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] sum;
  // return address, also the sequential pc
  logic [xlen-1:0] link;
  logic [xlen-1:0] jump_target;

  // auipc adds to pc, everything else to rs1
  assign op_a = dec.is_auipc ? pc : rs1_val;
  // imm forms skip rs2
  assign op_b = dec.need_imm ? dec.imm : rs2_val;

  // shared adder
  // addi result, auipc result or store address
  assign sum = op_a + op_b;

  assign link = pc + 64'd4;
  assign jump_target = pc + dec.imm;

  // only jal redirects
  assign next_pc = dec.is_jal ? jump_target : link;

  // jal writes the link address
  always_comb begin
    if (dec.is_jal) begin
      wb_data = link;
    end else if (dec.alu_add) begin
      wb_data = sum;
    end else begin
      wb_data = '0;
    end
  end

  // sd address is rs1 + imm
  assign mem_addr = sum;
  // store data straight from rs2
  assign mem_data = rs2_val;

endmodule

`default_nettype wire

/* regfile.sv */
`default_nettype none

module regfile import rv_pkg::*; (
  input logic clk,
  input logic reset,
  input logic [reg_id_width-1:0] rs1,
  input logic [reg_id_width-1:0] rs2,
  output logic [xlen-1:0] rs1_val,
  output logic [xlen-1:0] rs2_val,
  input logic wen,
  input logic [reg_id_width-1:0] wa,
  input logic [xlen-1:0] wd
);

  logic [xlen-1:0] regs [reg_count];

  // single write port, x0 never written
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (wa != '0)) begin
      regs[wa] <= wd;
    end
  end

  // async reads
  // x0 forced to zero
  always_comb begin
    if (rs1 == '0) begin
      rs1_val = '0;
    end else begin
      rs1_val = regs[rs1];
    end
  end

  always_comb begin
    if (rs2 == '0) begin
      rs2_val = '0;
    end else begin
      rs2_val = regs[rs2];
    end
  end

endmodule

`default_nettype wire

/* rv_core.sv */
`default_nettype none

module rv_core import rv_pkg::*; (
  input logic clk,
  input logic reset,
  output logic [xlen-1:0] wb_adr,
  output logic [xlen-1:0] wb_dat_w,
  input logic [xlen-1:0] wb_dat_r,
  output logic [mask_width-1:0] wb_sel,
  output logic wb_we,
  output logic wb_cyc,
  output logic wb_stb,
  input logic wb_ack,
  output logic [xlen-1:0] pc,
  output logic halted,
  output logic illegal
);

  logic [inst_width-1:0] inst;
  logic [xlen-1:0] rs1_val;
  logic [xlen-1:0] rs2_val;
  logic [xlen-1:0] next_pc;
  logic [xlen-1:0] wb_data;
  logic [xlen-1:0] mem_addr;
  logic [xlen-1:0] mem_data;
  logic reg_we;

  // decoded bundle shared by exec and control
  dec_if u_dec_if ();

  decoder u_decoder (
    .inst (inst),
    .dec  (u_dec_if)
  );

  // indices and rd taken from the decoded bundle
  regfile u_regfile (
    .clk     (clk),
    .reset   (reset),
    .rs1     (u_dec_if.rs1),
    .rs2     (u_dec_if.rs2),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .wen     (reg_we),
    .wa      (u_dec_if.rd),
    .wd      (wb_data)
  );

  exec_unit u_exec_unit (
    .pc       (pc),
    .rs1_val  (rs1_val),
    .rs2_val  (rs2_val),
    .dec      (u_dec_if),
    .next_pc  (next_pc),
    .wb_data  (wb_data),
    .mem_addr (mem_addr),
    .mem_data (mem_data)
  );

  // owns pc, ir and the wishbone master
  core_ctrl u_core_ctrl (
    .clk      (clk),
    .reset    (reset),
    .dec      (u_dec_if),
    .next_pc  (next_pc),
    .mem_addr (mem_addr),
    .mem_data (mem_data),
    .inst     (inst),
    .pc       (pc),
    .reg_we   (reg_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_sel   (wb_sel),
    .wb_we    (wb_we),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_ack   (wb_ack),
    .halted   (halted),
    .illegal  (illegal)
  );

endmodule

`default_nettype wire

/* rv_pkg.sv */
`default_nettype none

package rv_pkg;

  // datapath and register width
  localparam int xlen = 64;
  // fetched instruction width
  localparam int inst_width = 32;
  // register index width, 32 registers
  localparam int reg_id_width = 5;
  localparam int reg_count = 1 << reg_id_width;
  // one byte select per data byte
  localparam int mask_width = xlen / 8;

  // first fetch address after reset
  localparam logic [xlen-1:0] reset_pc = 64'h0000_0000_8000_0000;

  // funct3 values for the recognized forms
  localparam logic [2:0] f3_addi = 3'b000;
  localparam logic [2:0] f3_sd = 3'b011;
  localparam logic [2:0] f3_priv = 3'b000;
  // funct12 of ebreak
  localparam logic [11:0] f12_ebreak = 12'h001;

  // major opcodes, bits 6:0
  typedef enum logic [6:0] {
    opc_op_imm = 7'b0010011,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_store  = 7'b0100011,
    opc_system = 7'b1110011
  } opcode_e;

  // immediate format, picked by opcode
  typedef enum logic [2:0] {
    imm_none,
    imm_i,
    imm_u,
    imm_j,
    imm_s
  } imm_kind_e;

  // controller FSM
  typedef enum logic [1:0] {
    st_fetch,
    st_execute,
    st_store,
    st_halted
  } core_state_e;

endpackage

`default_nettype wire

/* sim.f */
rv_pkg.sv
dec_if.sv
decoder.sv
regfile.sv
exec_unit.sv
core_ctrl.sv
rv_core.sv
tb_clock.sv
tb_wb_mem.sv
core_checker.sv
tb_top.sv

/* tb_clock.sv */
`default_nettype none

module tb_clock #(
  parameter int period = 100,
  parameter int reset_cycles = 16,
  parameter int drive_delay = 10
) (
  output logic clk,
  output logic reset
);

  // free-running clock
  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // power-on reset, released just after an edge
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #drive_delay;
    reset = 1'b0;
  end

endmodule

`default_nettype wire

/* tb_top.sv */
`default_nettype none

module tb_top import rv_pkg::*; ();

  localparam int period = 100;
  localparam int reset_cycles = 16;
  localparam int drive_delay = 10;
  localparam int mem_words = 64;
  localparam int idle_cycles = 8;
  // worst case per instruction is a fetch plus a store with 3 wait states each
  localparam int cycles_per_inst = 16;
  // program lengths of the five tests
  localparam int total_insts = 6 + 3 + 5 + 4 + 4;
  localparam int num_tests = 5;
  localparam int watchdog_cycles = total_insts * cycles_per_inst +
                                   num_tests * (reset_cycles + idle_cycles + 4) + reset_cycles;

  logic clk;
  logic por_reset;
  logic test_reset;
  logic dut_reset;
  logic [xlen-1:0] wb_adr;
  logic [xlen-1:0] wb_dat_w;
  logic [xlen-1:0] wb_dat_r;
  logic [mask_width-1:0] wb_sel;
  logic wb_we;
  logic wb_cyc;
  logic wb_stb;
  logic wb_ack;
  logic [xlen-1:0] pc;
  logic halted;
  logic illegal;

  // program under test with one word per entry
  logic [inst_width-1:0] prog [$];
  // captured bus writes
  logic [xlen-1:0] wr_adr [$];
  logic [xlen-1:0] wr_dat [$];
  logic [mask_width-1:0] wr_sel [$];
  int ack_count;
  int error_count;
  int check_count;
  int passed;
  int failed;

  assign dut_reset = por_reset | test_reset;

  tb_clock #(.period(period), .reset_cycles(reset_cycles), .drive_delay(drive_delay)) u_clock (
    .clk   (clk),
    .reset (por_reset)
  );

  tb_wb_mem #(.mem_words(mem_words), .max_wait(3), .drive_delay(drive_delay), .seed(76381))
  u_mem (
    .clk      (clk),
    .reset    (dut_reset),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_sel   (wb_sel),
    .wb_we    (wb_we),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_ack   (wb_ack)
  );

  rv_core u_dut (
    .clk      (clk),
    .reset    (dut_reset),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_sel   (wb_sel),
    .wb_we    (wb_we),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_ack   (wb_ack),
    .pc       (pc),
    .halted   (halted),
    .illegal  (illegal)
  );

  // bus monitor sees completed transfers only
  always @(posedge clk) begin
    if (!dut_reset && wb_cyc && wb_stb && wb_ack) begin
      ack_count++;
      if (wb_we) begin
        wr_adr.push_back(wb_adr);
        wr_dat.push_back(wb_dat_w);
        wr_sel.push_back(wb_sel);
      end
    end
  end

  // encoders straight from the ISA formats
  function automatic logic [31:0] enc_addi(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, opc_op_imm};
  endfunction

  function automatic logic [31:0] enc_auipc(logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, opc_auipc};
  endfunction

  function automatic logic [31:0] enc_jal(logic [4:0] rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, opc_jal};
  endfunction

  function automatic logic [31:0] enc_sd(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] off);
    return {off[11:5], rs2, rs1, 3'b011, off[4:0], opc_store};
  endfunction

  function automatic logic [31:0] enc_ebreak();
    return {12'h001, 5'd0, 3'b000, 5'd0, opc_system};
  endfunction

  // background data that differs for every word index
  function automatic logic [xlen-1:0] fill_word(int i);
    return {~i[31:0], i[31:0] ^ 32'h5a5a_c3c3};
  endfunction

  function automatic int mem_index(logic [xlen-1:0] addr);
    return int'((addr >> 3) % mem_words);
  endfunction

  task automatic check(input string name, input logic [xlen-1:0] got,
                       input logic [xlen-1:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  // fill memory then place two instructions per doubleword from the reset pc
  task automatic load_memory();
    int i;
    int w;
    for (i = 0; i < mem_words; i++) begin
      u_mem.mem[i] = fill_word(i);
    end
    for (i = 0; i < prog.size(); i++) begin
      w = mem_index(reset_pc + 64'(4 * i));
      if (i % 2 == 1) begin
        u_mem.mem[w][63:32] = prog[i];
      end else begin
        u_mem.mem[w][31:0] = prog[i];
      end
    end
  endtask

  // reset, load, release and wait for halted
  task automatic run_program(input string name);
    int budget;
    int i;
    bit done;
    budget = prog.size() * cycles_per_inst;
    @(posedge clk);
    #drive_delay;
    test_reset = 1'b1;
    load_memory();
    wr_adr.delete();
    wr_dat.delete();
    wr_sel.delete();
    ack_count = 0;
    repeat (reset_cycles) @(posedge clk);
    #drive_delay;
    test_reset = 1'b0;
    done = 1'b0;
    for (i = 0; i < budget && !done; i++) begin
      @(posedge clk);
      #drive_delay;
      done = halted;
    end
    if (!done) begin
      error_count++;
      $display("test %s: core did not halt within %0d cycles", name, budget);
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (error_count == errs_before) begin
      passed++;
      $display("test %s: pass", name);
    end else begin
      failed++;
      $display("test %s: fail, %0d mismatches", name, error_count - errs_before);
    end
  endtask

  // one expected store plus halt flags
  task automatic expect_single_store(input logic [xlen-1:0] adr, input logic [xlen-1:0] dat);
    check("write count", wr_adr.size(), 1);
    check("wb_adr", wr_adr[0], adr);
    check("wb_dat_w", wr_dat[0], dat);
    check("wb_sel", 64'(wr_sel[0]), 64'hff);
    check("halted", 64'(halted), 1);
    check("illegal", 64'(illegal), 0);
    check("memory word", u_mem.mem[mem_index(adr)], dat);
  endtask

  task automatic addi_then_sd();
    int errs;
    errs = error_count;
    prog.delete();
    prog.push_back(enc_addi(5'd1, 5'd0, 12'd5));
    // -3
    prog.push_back(enc_addi(5'd2, 5'd0, 12'hffd));
    // padding keeps the sd and ebreak off the store target in doubleword 1
    prog.push_back(32'h0);
    prog.push_back(32'h0);
    prog.push_back(enc_sd(5'd2, 5'd1, 12'd8));
    prog.push_back(enc_ebreak());
    run_program("addi_sd");
    expect_single_store(64'd13, 64'hffff_ffff_ffff_fffd);
    finish_test("addi_sd", errs);
  endtask

  task automatic auipc_store();
    int errs;
    errs = error_count;
    prog.delete();
    prog.push_back(enc_auipc(5'd3, 20'd1));
    prog.push_back(enc_sd(5'd3, 5'd0, 12'h100));
    prog.push_back(enc_ebreak());
    run_program("auipc");
    // auipc sits at the reset pc
    expect_single_store(64'h100, reset_pc + 64'h1000);
    finish_test("auipc", errs);
  endtask

  task automatic jal_skip();
    int errs;
    errs = error_count;
    prog.delete();
    prog.push_back(enc_jal(5'd1, 21'd12));
    prog.push_back(enc_sd(5'd0, 5'd0, 12'h110));
    prog.push_back(enc_sd(5'd0, 5'd0, 12'h110));
    prog.push_back(enc_sd(5'd1, 5'd0, 12'h108));
    prog.push_back(enc_ebreak());
    run_program("jal");
    expect_single_store(64'h108, reset_pc + 64'd4);
    // skipped store target untouched
    check("skipped word", u_mem.mem[mem_index(64'h110)], fill_word(mem_index(64'h110)));
    finish_test("jal", errs);
  endtask

  task automatic x0_nop();
    int errs;
    errs = error_count;
    prog.delete();
    prog.push_back(enc_addi(5'd0, 5'd0, 12'd7));
    prog.push_back(32'h0);
    prog.push_back(enc_sd(5'd0, 5'd0, 12'h118));
    prog.push_back(enc_ebreak());
    run_program("x0_nop");
    expect_single_store(64'h118, 64'h0);
    finish_test("x0_nop", errs);
  endtask

  task automatic illegal_stop();
    int errs;
    int acks;
    errs = error_count;
    prog.delete();
    prog.push_back(enc_addi(5'd5, 5'd0, 12'd1));
    // ld x6, 0(x0)
    prog.push_back({12'h0, 5'd0, 3'b011, 5'd6, 7'b0000011});
    prog.push_back(enc_sd(5'd5, 5'd0, 12'h120));
    prog.push_back(enc_ebreak());
    run_program("illegal");
    acks = ack_count;
    repeat (idle_cycles) @(posedge clk);
    #drive_delay;
    check("halted", 64'(halted), 1);
    check("illegal", 64'(illegal), 1);
    check("pc", pc, reset_pc + 64'd4);
    check("write count", wr_adr.size(), 0);
    check("acks after halt", ack_count, acks);
    check("wb_cyc", 64'(wb_cyc), 0);
    finish_test("illegal", errs);
  endtask

  // run limit
  initial begin
    #(watchdog_cycles * period);
    $display("watchdog expired after %0d cycles", watchdog_cycles);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    test_reset = 1'b0;
    error_count = 0;
    check_count = 0;
    passed = 0;
    failed = 0;
    ack_count = 0;
    @(negedge por_reset);
    addi_then_sd();
    auipc_store();
    jal_skip();
    x0_nop();
    illegal_stop();
    $display("tests %0d, passed %0d, failed %0d, checks %0d, mismatches %0d, assertions %0d",
             passed + failed, passed, failed, check_count, error_count,
             u_dut.u_checker.fail_count);
    if (error_count == 0 && failed == 0 && u_dut.u_checker.fail_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb_wb_mem.sv */
`default_nettype none

module tb_wb_mem import rv_pkg::*; #(
  parameter int mem_words = 64,
  parameter int max_wait = 3,
  parameter int drive_delay = 10,
  parameter int seed = 1
) (
  input logic clk,
  input logic reset,
  input logic [xlen-1:0] wb_adr,
  input logic [xlen-1:0] wb_dat_w,
  output logic [xlen-1:0] wb_dat_r,
  input logic [mask_width-1:0] wb_sel,
  input logic wb_we,
  input logic wb_cyc,
  input logic wb_stb,
  output logic wb_ack
);

  localparam int addr_bits = $clog2(mem_words);

  // doubleword array, filled by the testbench
  logic [xlen-1:0] mem [mem_words];
  // transfer in progress and wait states still owed
  logic busy;
  int wait_left;
  bit seeded;

  initial begin
    wb_ack = 1'b0;
    wb_dat_r = '0;
    busy = 1'b0;
    wait_left = 0;
    seeded = 1'b0;
  end

  // sample at the edge, answer a little later
  always @(posedge clk) begin
    logic next_ack;
    logic [xlen-1:0] next_dat;
    int idx;
    int b;
    if (!seeded) begin
      void'($urandom(seed));
      seeded = 1'b1;
    end
    next_ack = 1'b0;
    next_dat = wb_dat_r;
    // only the address bits below the array size
    idx = int'(wb_adr[addr_bits+2:3]);
    if (reset) begin
      busy = 1'b0;
    end else if (wb_ack) begin
      // single-cycle ack, master drops stb on this edge
      busy = 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (!busy) begin
        busy = 1'b1;
        wait_left = $urandom_range(max_wait, 0);
      end
      if (wait_left == 0) begin
        next_ack = 1'b1;
        if (wb_we) begin
          // byte lanes gated by sel
          for (b = 0; b < mask_width; b++) begin
            if (wb_sel[b]) begin
              mem[idx][8*b +: 8] = wb_dat_w[8*b +: 8];
            end
          end
        end else begin
          next_dat = mem[idx];
        end
      end else begin
        wait_left--;
      end
    end
    #drive_delay;
    wb_ack = next_ack;
    wb_dat_r = next_dat;
  end

endmodule

`default_nettype wire
